// ==== logic/emmc_config.svh ====
`ifndef EMMC_CONFIG_SVH
`define EMMC_CONFIG_SVH

// field widths
`define EMMC_ARG_W      32
`define EMMC_IDX_W      6
`define EMMC_FRAME_W    48
`define EMMC_DIV_W      8
`define EMMC_INT_W      5

`define EMMC_NCR_MAX    64      // sd rises allowed before the start bit
`define EMMC_DIV_RESET  2

// apb register map
`define EMMC_REG_CLKDIV    8'h00
`define EMMC_REG_ARG       8'h04
`define EMMC_REG_CMD       8'h08    // [5:0] index, [9:8] response type
`define EMMC_REG_STATUS    8'h0C    // bit 0 busy
`define EMMC_REG_INT_STAT  8'h10
`define EMMC_REG_INT_EN    8'h14
`define EMMC_REG_RESP0     8'h18
`define EMMC_REG_RESP1     8'h1C

`endif

// ==== logic/emmc_pkg.sv ====
`include "emmc_config.svh"

package emmc_pkg;

    typedef enum logic [1:0] {
        RESP_NONE = 2'd0,
        RESP_R1   = 2'd1,
        RESP_R3   = 2'd2
    } resp_type_e;

    typedef struct packed {
        logic [`EMMC_IDX_W-1:0] index;
        logic [`EMMC_ARG_W-1:0] argument;
        resp_type_e             resp_type;
    } cmd_req_t;

    // r1 card status, error bits on top
    typedef struct packed {
        logic [12:0] error;
        logic [5:0]  status_hi;
        logic [3:0]  current_state;
        logic [8:0]  status_lo;
    } r1_status_t;

    typedef struct packed {
        logic        busy;              // low while card powers up
        logic [1:0]  access_mode;
        logic [4:0]  reserved;
        logic [23:0] voltage;
    } ocr_t;

    // r1 and r3 share the 32 bit payload slot
    typedef union packed {
        r1_status_t r1;
        ocr_t       ocr;
    } resp_payload_u;

    typedef struct packed {
        resp_payload_u payload;
        logic          timeout;
        logic          crc_err;
        logic          idx_err;
        logic          card_err;
        logic          done;
    } lane_result_t;

    typedef struct packed {
        logic card_err;
        logic idx_err;
        logic crc_err;
        logic timeout;
        logic cmd_done;
    } int_stat_t;

    // one bit of crc7, poly x^7 + x^3 + 1
    function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic bit_in);
        logic fb;
        fb = crc[6] ^ bit_in;
        crc7_step = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

endpackage

// ==== logic/sd_clk_divider.sv ====
`timescale 1ns/10ps
`include "emmc_config.svh"

module sd_clk_divider (
    input  logic                   s00_axi_aclk,
    input  logic                   arst_n_i,
    input  logic [`EMMC_DIV_W-1:0] divisor_i,
    output logic                   sd_clk_o,
    output logic                   sd_rise_o,
    output logic                   sd_fall_o
);
    localparam int DIV_W = `EMMC_DIV_W;

    logic [DIV_W-1:0] cnt;
    logic [DIV_W-1:0] div_eff;
    logic             tick;

    assign div_eff = (divisor_i == '0) ? DIV_W'(1) : divisor_i;   // clamp to 1
    assign tick    = (cnt >= div_eff);

    always_ff @(posedge s00_axi_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt      <= '0;
            sd_clk_o <= 1'b0;
        end else if (tick) begin
            cnt      <= '0;
            sd_clk_o <= ~sd_clk_o;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // flag the cycle whose edge moves the pin
    assign sd_rise_o = tick & ~sd_clk_o;
    assign sd_fall_o = tick & sd_clk_o;

endmodule

// ==== logic/emmc_cmd_lane.sv ====
`timescale 1ns/10ps
`include "emmc_config.svh"

module emmc_cmd_lane (
    input  logic                   s00_axi_aclk,
    input  logic                   arst_n_i,
    input  logic                   sd_rise_i,
    input  logic                   sd_fall_i,
    input  logic                   go_i,
    input  emmc_pkg::cmd_req_t     cmd_i,
    input  logic                   cmd_in_i,
    output logic                   cmd_out_o,
    output logic                   cmd_oe_o,
    output emmc_pkg::lane_result_t result_o
);
    import emmc_pkg::*;

    localparam int FRAME_W = `EMMC_FRAME_W;
    localparam int HDR_W   = `EMMC_IDX_W + `EMMC_ARG_W + 2;     // start, dir, index, arg
    localparam int NCR_W   = $clog2(`EMMC_NCR_MAX + 1);

    typedef enum logic [2:0] {ST_IDLE, ST_TX, ST_WAIT, ST_RX, ST_CHECK} lane_state_e;

    lane_state_e      state;
    logic [HDR_W-1:0] out_sr;
    logic [6:0]       tx_crc;
    logic [5:0]       bit_cnt;
    logic [FRAME_W-1:0] in_sr;
    logic [6:0]       rx_crc;
    logic [NCR_W-1:0] ncr;
    logic             rx_active;
    logic             is_r1;
    resp_payload_u    rx_payload;

    assign rx_active  = (state == ST_WAIT) || (state == ST_RX);
    assign is_r1      = (cmd_i.resp_type == RESP_R1);
    assign rx_payload = in_sr[8 +: `EMMC_ARG_W];

    // frame header, loaded on go
    always_ff @(posedge s00_axi_aclk) begin
        if (go_i)
            out_sr <= {2'b01, cmd_i.index, cmd_i.argument};
        else if (state == ST_TX && sd_fall_i && bit_cnt < HDR_W)
            out_sr <= {out_sr[HDR_W-2:0], 1'b0};
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (rx_active && sd_rise_i)
            in_sr <= {in_sr[FRAME_W-2:0], cmd_in_i};
    end

    always_ff @(posedge s00_axi_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= ST_IDLE;
            cmd_out_o <= 1'b1;
            cmd_oe_o  <= 1'b0;
            bit_cnt   <= '0;
            tx_crc    <= '0;
            rx_crc    <= '0;
            ncr       <= '0;
            result_o  <= '0;
        end else if (go_i) begin
            state    <= ST_TX;
            bit_cnt  <= '0;
            tx_crc   <= '0;
            result_o <= '0;     // done drops until this command ends
        end else begin
            case (state)
                ST_TX: if (sd_fall_i) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt < HDR_W) begin
                        cmd_oe_o  <= 1'b1;
                        cmd_out_o <= out_sr[HDR_W-1];
                        tx_crc    <= crc7_step(tx_crc, out_sr[HDR_W-1]);
                    end else if (bit_cnt < FRAME_W - 1) begin
                        cmd_out_o <= tx_crc[6];
                        tx_crc    <= {tx_crc[5:0], 1'b0};
                    end else if (bit_cnt == FRAME_W - 1) begin
                        cmd_out_o <= 1'b1;  // end bit
                    end else begin
                        cmd_oe_o  <= 1'b0;
                        cmd_out_o <= 1'b1;
                        bit_cnt   <= '0;
                        ncr       <= '0;
                        if (cmd_i.resp_type == RESP_NONE) begin
                            result_o.done <= 1'b1;
                            state         <= ST_IDLE;
                        end else begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: if (sd_rise_i) begin
                    if (!cmd_in_i) begin
                        state   <= ST_RX;
                        bit_cnt <= 6'd1;
                        rx_crc  <= '0;  // start bit leaves crc at zero
                    end else if (ncr == NCR_W'(`EMMC_NCR_MAX - 1)) begin
                        result_o.timeout <= 1'b1;
                        result_o.done    <= 1'b1;
                        state            <= ST_IDLE;
                    end else begin
                        ncr <= ncr + 1'b1;
                    end
                end
                ST_RX: if (sd_rise_i) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt < HDR_W)
                        rx_crc <= crc7_step(rx_crc, cmd_in_i);
                    if (bit_cnt == FRAME_W - 1)
                        state <= ST_CHECK;
                end
                ST_CHECK: begin
                    // r3 carries all ones where the crc would be
                    result_o.payload  <= rx_payload;
                    result_o.crc_err  <= is_r1 && (in_sr[7:1] != rx_crc);
                    result_o.idx_err  <= is_r1 && (in_sr[40 +: `EMMC_IDX_W] != cmd_i.index);
                    result_o.card_err <= is_r1 && (rx_payload.r1.error != '0);
                    result_o.done     <= 1'b1;
                    state             <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/cmd_master.sv ====
`timescale 1ns/10ps
`include "emmc_config.svh"

module cmd_master (
    input  logic                   s00_axi_aclk,
    input  logic                   arst_n_i,
    input  logic                   start_i,
    input  emmc_pkg::cmd_req_t     cmd_i,
    input  emmc_pkg::lane_result_t lane0_res_i,
    input  emmc_pkg::lane_result_t lane1_res_i,
    output logic                   lane_go_o,
    output emmc_pkg::cmd_req_t     lane_cmd_o,
    output logic                   busy_o,
    output emmc_pkg::int_stat_t    stat_set_o,
    output logic [`EMMC_ARG_W-1:0] resp0_o,
    output logic [`EMMC_ARG_W-1:0] resp1_o
);
    import emmc_pkg::*;

    cmd_req_t cmd_q;
    logic     busy_q;
    logic     go_q;
    logic     finish;

    // lanes still show the old done bits while go is out
    assign finish     = busy_q & ~go_q & lane0_res_i.done & lane1_res_i.done;
    assign busy_o     = busy_q | start_i;
    assign lane_go_o  = go_q;
    assign lane_cmd_o = cmd_q;

    always_ff @(posedge s00_axi_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmd_q   <= '0;
            busy_q  <= 1'b0;
            go_q    <= 1'b0;
            resp0_o <= '0;
            resp1_o <= '0;
        end else begin
            go_q <= start_i & ~busy_q;
            if (start_i && !busy_q) begin
                cmd_q  <= cmd_i;
                busy_q <= 1'b1;
            end else if (finish) begin
                busy_q  <= 1'b0;
                resp0_o <= lane0_res_i.payload;
                resp1_o <= lane1_res_i.payload;
            end
        end
    end

    // events land in int_stat on the edge that clears busy
    always_comb begin
        stat_set_o = '0;
        if (finish) begin
            stat_set_o.cmd_done = 1'b1;
            stat_set_o.timeout  = lane0_res_i.timeout | lane1_res_i.timeout;
            stat_set_o.crc_err  = lane0_res_i.crc_err | lane1_res_i.crc_err;
            stat_set_o.idx_err  = lane0_res_i.idx_err | lane1_res_i.idx_err;
            stat_set_o.card_err = lane0_res_i.card_err | lane1_res_i.card_err;
        end
    end

endmodule

// ==== logic/host_regs_apb.sv ====
`timescale 1ns/10ps
`include "emmc_config.svh"

module host_regs_apb (
    input  logic                   s00_axi_aclk,
    input  logic                   arst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [7:0]             paddr_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic                   busy_i,
    input  emmc_pkg::int_stat_t    stat_set_i,
    input  logic [`EMMC_ARG_W-1:0] resp0_i,
    input  logic [`EMMC_ARG_W-1:0] resp1_i,
    output logic [`EMMC_DIV_W-1:0] divisor_o,
    output emmc_pkg::cmd_req_t     cmd_o,
    output logic                   start_o,
    output logic                   interrupt_o
);
    import emmc_pkg::*;

    localparam logic [`EMMC_DIV_W-1:0] DIV_RESET = `EMMC_DIV_RESET;

    logic                   wr_en;
    logic                   cmd_wr;
    logic [`EMMC_INT_W-1:0] w1c;
    logic [`EMMC_DIV_W-1:0] clkdiv_q;
    logic [`EMMC_INT_W-1:0] int_en_q;
    cmd_req_t               cmd_q;
    int_stat_t              int_stat_q;

    assign wr_en  = psel_i & penable_i & pwrite_i;
    assign cmd_wr = wr_en && (paddr_i == `EMMC_REG_CMD);
    assign w1c    = (wr_en && paddr_i == `EMMC_REG_INT_STAT) ? pwdata_i[`EMMC_INT_W-1:0] : '0;

    assign pready_o    = 1'b1;
    assign pslverr_o   = cmd_wr & busy_i;      // command already running
    assign divisor_o   = clkdiv_q;
    assign cmd_o       = cmd_q;
    assign interrupt_o = |(int_stat_q & int_en_q);

    always_ff @(posedge s00_axi_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clkdiv_q   <= DIV_RESET;
            int_en_q   <= '0;
            cmd_q      <= '0;
            int_stat_q <= '0;
            start_o    <= 1'b0;
        end else begin
            start_o    <= cmd_wr & ~busy_i;
            int_stat_q <= (int_stat_q & ~w1c) | stat_set_i;     // set beats clear
            if (wr_en) begin
                case (paddr_i)
                    `EMMC_REG_CLKDIV: clkdiv_q <= pwdata_i[`EMMC_DIV_W-1:0];
                    `EMMC_REG_ARG:    cmd_q.argument <= pwdata_i;
                    `EMMC_REG_CMD: if (!busy_i) begin
                        cmd_q.index     <= pwdata_i[`EMMC_IDX_W-1:0];
                        cmd_q.resp_type <= resp_type_e'(pwdata_i[9:8]);
                    end
                    `EMMC_REG_INT_EN: int_en_q <= pwdata_i[`EMMC_INT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            `EMMC_REG_CLKDIV:   prdata_o[`EMMC_DIV_W-1:0] = clkdiv_q;
            `EMMC_REG_ARG:      prdata_o = cmd_q.argument;
            `EMMC_REG_CMD: begin
                prdata_o[`EMMC_IDX_W-1:0] = cmd_q.index;
                prdata_o[9:8]             = cmd_q.resp_type;
            end
            `EMMC_REG_STATUS:   prdata_o[0] = busy_i;
            `EMMC_REG_INT_STAT: prdata_o[`EMMC_INT_W-1:0] = int_stat_q;
            `EMMC_REG_INT_EN:   prdata_o[`EMMC_INT_W-1:0] = int_en_q;
            `EMMC_REG_RESP0:    prdata_o = resp0_i;
            `EMMC_REG_RESP1:    prdata_o = resp1_i;
            default:            prdata_o = '0;
        endcase
    end

endmodule

// ==== logic/raid0_cmd_host.sv ====
`timescale 1ns/10ps
`include "emmc_config.svh"

module raid0_cmd_host (
    input  logic        s00_axi_aclk,
    input  logic        arst_n_i,
    // apb slave
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    // emmc pins, card 0 and card 1
    output logic        sd_clk_o,
    output logic        sd_cmd_o,
    output logic        sd_cmd_t_o,
    input  logic        sd_cmd_i,
    output logic        sd_cmd1_o,
    output logic        sd_cmd1_t_o,
    input  logic        sd_cmd1_i,
    output logic        interrupt_o
);
    import emmc_pkg::*;

    logic [`EMMC_DIV_W-1:0] divisor;
    logic                   sd_rise;
    logic                   sd_fall;
    logic                   cmd_start;
    logic                   busy;
    logic                   lane_go;
    cmd_req_t               host_cmd;
    cmd_req_t               lane_cmd;
    int_stat_t              stat_set;
    lane_result_t           lane0_res;
    lane_result_t           lane1_res;
    logic [`EMMC_ARG_W-1:0] resp0;
    logic [`EMMC_ARG_W-1:0] resp1;

    host_regs_apb host_regs_apb_inst (
        .s00_axi_aclk (s00_axi_aclk), .arst_n_i (arst_n_i),
        .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
        .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
        .pready_o (pready_o), .pslverr_o (pslverr_o),
        .busy_i (busy), .stat_set_i (stat_set), .resp0_i (resp0), .resp1_i (resp1),
        .divisor_o (divisor), .cmd_o (host_cmd), .start_o (cmd_start),
        .interrupt_o (interrupt_o)
    );

    sd_clk_divider sd_clk_divider_inst (
        .s00_axi_aclk (s00_axi_aclk), .arst_n_i (arst_n_i), .divisor_i (divisor),
        .sd_clk_o (sd_clk_o), .sd_rise_o (sd_rise), .sd_fall_o (sd_fall)
    );

    cmd_master cmd_master_inst (
        .s00_axi_aclk (s00_axi_aclk), .arst_n_i (arst_n_i),
        .start_i (cmd_start), .cmd_i (host_cmd),
        .lane0_res_i (lane0_res), .lane1_res_i (lane1_res),
        .lane_go_o (lane_go), .lane_cmd_o (lane_cmd), .busy_o (busy),
        .stat_set_o (stat_set), .resp0_o (resp0), .resp1_o (resp1)
    );

    // both lanes run the same frame in lockstep
    emmc_cmd_lane lane0 (
        .s00_axi_aclk (s00_axi_aclk), .arst_n_i (arst_n_i),
        .sd_rise_i (sd_rise), .sd_fall_i (sd_fall), .go_i (lane_go), .cmd_i (lane_cmd),
        .cmd_in_i (sd_cmd_i), .cmd_out_o (sd_cmd_o), .cmd_oe_o (sd_cmd_t_o),
        .result_o (lane0_res)
    );

    emmc_cmd_lane lane1 (
        .s00_axi_aclk (s00_axi_aclk), .arst_n_i (arst_n_i),
        .sd_rise_i (sd_rise), .sd_fall_i (sd_fall), .go_i (lane_go), .cmd_i (lane_cmd),
        .cmd_in_i (sd_cmd1_i), .cmd_out_o (sd_cmd1_o), .cmd_oe_o (sd_cmd1_t_o),
        .result_o (lane1_res)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;  // 8 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end
endmodule

// ==== test/raid0_cmd_host_sva.sv ====
`timescale 1ns/10ps

module raid0_cmd_host_sva (
    input logic clk_i,
    input logic arst_n_i,
    input logic rx_active_i,
    input logic oe_i,
    input logic out_i,
    input logic psel_i,
    input logic penable_i,
    input logic pslverr_i
);
    // card owns the line while a response is due
    assert property (@(posedge clk_i) disable iff (!arst_n_i) rx_active_i |-> !oe_i)
        else $error("lane drove the command line during its receive phase");

    assert property (@(posedge clk_i) disable iff (!arst_n_i) !oe_i |-> out_i)
        else $error("released command line is not parked high");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pslverr_i |-> psel_i && penable_i)
        else $error("pslverr raised outside an access phase");
endmodule

bind emmc_cmd_lane raid0_cmd_host_sva lane_sva_inst (
    .clk_i (s00_axi_aclk), .arst_n_i (arst_n_i), .rx_active_i (rx_active),
    .oe_i (cmd_oe_o), .out_i (cmd_out_o),
    .psel_i (1'b0), .penable_i (1'b0), .pslverr_i (1'b0)
);

bind host_regs_apb raid0_cmd_host_sva apb_sva_inst (
    .clk_i (s00_axi_aclk), .arst_n_i (arst_n_i), .rx_active_i (1'b0),
    .oe_i (1'b0), .out_i (1'b1),
    .psel_i (psel_i), .penable_i (penable_i), .pslverr_i (pslverr_o)
);

// ==== test/raid0_cmd_host_tb.sv ====
`timescale 1ns/10ps
`include "emmc_config.svh"

module raid0_cmd_host_tb;
    import emmc_pkg::*;

    localparam int NUM_CMDS = 7;
    localparam int LIMIT    = NUM_CMDS * (`EMMC_DIV_RESET + 1) * 2 * 170 + 500;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        sd_clk;
    logic        irq;
    wire  [1:0]  cmd_out;
    wire  [1:0]  cmd_oe;
    logic [1:0]  cmd_in;
    logic [31:0] stim [0:NUM_CMDS*8-1];    // 8 words per command
    logic [31:0] lfsr;
    int          cycles = 0;

    tb_clk_gen tb_clk_gen_inst (.clk_o (clk), .arst_n_o (arst_n));

    raid0_cmd_host raid0_cmd_host_inst (
        .s00_axi_aclk (clk), .arst_n_i (arst_n),
        .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
        .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
        .sd_clk_o (sd_clk), .sd_cmd_o (cmd_out[0]), .sd_cmd_t_o (cmd_oe[0]),
        .sd_cmd_i (cmd_in[0]), .sd_cmd1_o (cmd_out[1]), .sd_cmd1_t_o (cmd_oe[1]),
        .sd_cmd1_i (cmd_in[1]), .interrupt_o (irq)
    );

    // crc7 over a 40 bit header sent msb first
    function automatic logic [6:0] crc7_of(input logic [39:0] d);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = c[6] ^ d[i];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic check_val(input string name, input logic [47:0] got, input logic [47:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns on %s, got %h, expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        logic [1:0] gap;
        lfsr   = lfsr_step(lfsr);
        gap[0] = lfsr[0];
        lfsr   = lfsr_step(lfsr);
        gap[1] = lfsr[0];
        repeat (gap) @(negedge clk);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        check_val("pready_o", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_val("pslverr_o", err, 1'b0);
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rd, err);
        check_val(name, rd, exp);
    endtask

    // card model applying the line's fault code
    task automatic serve_card(input int ln, input logic [47:0] exp_frame, input logic [1:0] rtype,
                              input logic [31:0] payload, input logic [3:0] fault);
        logic [47:0] rx;
        logic [47:0] tx;
        logic [5:0]  ridx;
        logic [6:0]  rcrc;
        rx = '0;
        do @(posedge sd_clk); while (!(cmd_oe[ln] && !cmd_out[ln]));
        repeat (47) begin
            @(posedge sd_clk);
            check_val($sformatf("lane%0d sd_cmd_t_o", ln), cmd_oe[ln], 1'b1);
            rx = {rx[46:0], cmd_out[ln]};
        end
        check_val($sformatf("lane%0d command frame", ln), rx, exp_frame);
        @(posedge sd_clk);
        check_val($sformatf("lane%0d sd_cmd_t_o", ln), cmd_oe[ln], 1'b0);  // released after end bit
        if (rtype != 2'd0 && fault != 4'd2) begin
            ridx = (rtype == 2'd2) ? 6'h3F : exp_frame[45:40];
            if (fault == 4'd3)
                ridx = ridx ^ 6'h01;
            rcrc = (rtype == 2'd2) ? 7'h7F : crc7_of({2'b00, ridx, payload});  // r3 has no crc
            if (fault == 4'd1)
                rcrc = rcrc ^ 7'h01;
            tx = {2'b00, ridx, payload, rcrc, 1'b1};
            @(negedge sd_clk);
            for (int i = 47; i >= 0; i--) begin
                cmd_in[ln] <= tx[i];
                @(negedge sd_clk);
            end
            cmd_in[ln] <= 1'b1;
        end
    endtask

    task automatic run_command(input logic [5:0] idx, input logic [31:0] arg,
                               input logic [1:0] rtype);
        logic [31:0] rd;
        logic        err;
        reg_write(`EMMC_REG_ARG, arg);
        reg_write(`EMMC_REG_CMD, {22'd0, rtype, 2'b00, idx});
        read_expect("STATUS", `EMMC_REG_STATUS, 32'd1);
        apb_xfer(1'b1, `EMMC_REG_CMD, {22'd0, 2'd1, 2'b00, ~idx}, rd, err);  // must bounce
        check_val("pslverr_o", err, 1'b1);
        do
            apb_xfer(1'b0, `EMMC_REG_STATUS, 32'd0, rd, err);
        while (rd[0]);
        read_expect("CMD", `EMMC_REG_CMD, {22'd0, rtype, 2'b00, idx});
    endtask

    initial begin
        logic [39:0] hdr;
        logic [47:0] frame;
        logic [4:0]  en;
        logic [4:0]  exp_stat;
        int          base;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        cmd_in  = 2'b11;
        lfsr    = 32'hd887;
        $readmemh("test/cmd_stim.hex", stim);
        wait (arst_n);
        @(negedge clk);
        read_expect("CLKDIV", `EMMC_REG_CLKDIV, `EMMC_DIV_RESET);
        read_expect("STATUS", `EMMC_REG_STATUS, 32'd0);
        read_expect("INT_STAT", `EMMC_REG_INT_STAT, 32'd0);
        check_val("interrupt_o", irq, 1'b0);
        for (int c = 0; c < NUM_CMDS; c++) begin
            base     = c * 8;
            hdr      = {2'b01, stim[base][5:0], stim[base+1]};
            frame    = {hdr, crc7_of(hdr), 1'b1};
            exp_stat = stim[base+7][4:0];
            en       = 5'd1 << (c % 5);     // walk the enable bit
            reg_write(`EMMC_REG_INT_EN, {27'd0, en});
            fork
                serve_card(0, frame, stim[base+2][1:0], stim[base+3], stim[base+5][3:0]);
                serve_card(1, frame, stim[base+2][1:0], stim[base+4], stim[base+6][3:0]);
                run_command(stim[base][5:0], stim[base+1], stim[base+2][1:0]);
            join
            read_expect("RESP0", `EMMC_REG_RESP0, stim[base+3]);
            read_expect("RESP1", `EMMC_REG_RESP1, stim[base+4]);
            read_expect("INT_STAT", `EMMC_REG_INT_STAT, {27'd0, exp_stat});
            check_val("interrupt_o", irq, |(exp_stat & en));
            reg_write(`EMMC_REG_INT_STAT, {27'd0, exp_stat});
            read_expect("INT_STAT", `EMMC_REG_INT_STAT, 32'd0);
            check_val("interrupt_o", irq, 1'b0);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout after %0d cycles, a command never finished", cycles);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== raid0_cmd_host.f ====
+incdir+logic
logic/emmc_pkg.sv
logic/sd_clk_divider.sv
logic/emmc_cmd_lane.sv
logic/cmd_master.sv
logic/host_regs_apb.sv
logic/raid0_cmd_host.sv
test/tb_clk_gen.sv
test/raid0_cmd_host_sva.sv
test/raid0_cmd_host_tb.sv

// ==== Makefile ====
TOP := raid0_cmd_host_tb

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f raid0_cmd_host.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== test/cmd_stim.hex ====
// index argument resp_type payload0 payload1 fault0 fault1 int_stat
// resp_type 0 none 1 r1 2 r3, fault 0 none 1 bad crc 2 silent 3 wrong index
0D 00010000 1 00000900 00000900 0 0 01
01 40FF8080 2 C0FF8080 C0FF8080 1 0 01
11 00000200 1 00000900 00000900 0 1 05
07 12340000 1 00000700 00000700 3 0 09
0D 00010000 1 80000900 00000900 0 0 11
06 03B70100 1 00000800 00000000 0 2 03
00 00000000 0 00000000 00000000 0 0 01
